// ==== Bender.yml ====
package:
  name: arp_engine

sources:
  - arp_pkg.sv
  - arp_table_ram.sv
  - arp_table.sv
  - arp_rx.sv
  - arp_tx.sv
  - arp_top.sv
  - target: test
    files:
      - tb_arp.sv

// ==== all.f ====
arp_pkg.sv
arp_table_ram.sv
arp_table.sv
arp_rx.sv
arp_tx.sv
arp_top.sv
tb_arp.sv

// ==== arp_pkg.sv ====
`default_nettype none

package arp_pkg;

  // Addresses go out most significant byte first
  typedef logic [31:0] ipv4_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] arp_oper_t;

  localparam arp_oper_t OPER_REQUEST = 16'd1;
  localparam arp_oper_t OPER_REPLY   = 16'd2;

  localparam logic [15:0] ETHERTYPE_ARP = 16'h0806;

  localparam int ARP_HDR_LEN   = 28; // Bytes that carry fields
  localparam int ARP_FRAME_LEN = 46; // Fields plus 18 zero pad bytes

  localparam mac_addr_t BROADCAST_MAC = '1;

endpackage

`default_nettype wire

// ==== arp_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module arp_rx (
  input  logic               clk,
  input  logic               fsm_rst,
  input  arp_pkg::ipv4_t     dev_ipv4,
  input  arp_pkg::byte_t     rx_d,
  input  logic               rx_v,
  input  logic [15:0]        rx_ethertype,
  input  logic               rx_err,
  output logic               learn_v,
  output arp_pkg::ipv4_t     learn_ipv4,
  output arp_pkg::mac_addr_t learn_mac,
  output logic               reply_req,
  output arp_pkg::ipv4_t     reply_dst_ipv4,
  output arp_pkg::mac_addr_t reply_dst_mac
);

  localparam int HDR_W = arp_pkg::ARP_HDR_LEN * 8;

  logic [HDR_W-1:0]  hdr;
  logic [5:0]        byte_cnt;
  logic              frame_done;
  logic              drop;      // Rest of an aborted frame
  logic              arp_byte;
  arp_pkg::arp_oper_t oper;
  arp_pkg::ipv4_t    tgt_ipv4;

  assign arp_byte = rx_v && (rx_ethertype == arp_pkg::ETHERTYPE_ARP);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      byte_cnt   <= '0;
      frame_done <= 1'b0;
      drop       <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      if (rx_err || (arp_byte && byte_cnt == 6'(arp_pkg::ARP_FRAME_LEN))) begin
        byte_cnt <= '0;
        drop     <= 1'b1;
      end else if (!arp_byte) begin
        byte_cnt <= '0; // Gap ends the frame
        drop     <= 1'b0;
      end else if (!drop) begin
        byte_cnt <= byte_cnt + 6'd1;
        if (byte_cnt == 6'(arp_pkg::ARP_FRAME_LEN - 1)) frame_done <= 1'b1;
      end
    end
  end

  // Only the field bytes are kept, the padding falls away
  always_ff @(posedge clk) begin
    if (arp_byte && !drop && byte_cnt < 6'(arp_pkg::ARP_HDR_LEN)) begin
      hdr <= {hdr[HDR_W-9:0], rx_d};
    end
  end

  // Big-endian layout of the 28 field bytes
  assign oper           = hdr[175:160];
  assign learn_mac      = hdr[159:112]; // Sender MAC
  assign learn_ipv4     = hdr[111:80];  // Sender IP
  assign tgt_ipv4       = hdr[31:0];
  assign reply_dst_mac  = learn_mac;
  assign reply_dst_ipv4 = learn_ipv4;

  // A 47th byte or an error in the cycle after the 46th cancels the frame
  assign learn_v   = frame_done && !arp_byte && !rx_err;
  assign reply_req = learn_v && (oper == arp_pkg::OPER_REQUEST) && (tgt_ipv4 == dev_ipv4);

  a_learn_single : assert property (@(posedge clk) disable iff (fsm_rst)
    learn_v |=> !learn_v);

endmodule

`default_nettype wire

// ==== arp_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module arp_table #(
  parameter int TABLE_ADDR_W      = 2,
  parameter int ARP_TIMEOUT_TICKS = 1000000
) (
  input  logic               clk,
  input  logic               fsm_rst,
  input  logic               learn_v,
  input  arp_pkg::ipv4_t     learn_ipv4,
  input  arp_pkg::mac_addr_t learn_mac,
  input  arp_pkg::ipv4_t     ipv4_req,
  output arp_pkg::mac_addr_t mac_rsp,
  output logic               arp_val,
  output logic               arp_err,
  input  logic               tx_busy,
  output logic               send_req,
  output arp_pkg::ipv4_t     req_dst_ipv4
);

  localparam int ENTRIES = 2 ** TABLE_ADDR_W;
  localparam int MAC_W   = $bits(arp_pkg::mac_addr_t);
  localparam int TMO_W   = $clog2(ARP_TIMEOUT_TICKS + 1);

  typedef enum logic [1:0] {w_idle_s, w_scan_s, w_update_s, w_add_s} w_state_t;
  typedef enum logic [1:0] {r_idle_s, r_scan_s, r_wait_tx_s, r_wait_reply_s} r_state_t;

  w_state_t                w_state;
  r_state_t                r_state;
  logic [TABLE_ADDR_W-1:0] a_addr;
  logic [TABLE_ADDR_W-1:0] b_addr;
  logic [TABLE_ADDR_W-1:0] w_cmp_idx;
  logic [TABLE_ADDR_W-1:0] r_cmp_idx;
  logic [TABLE_ADDR_W-1:0] w_ptr;    // Round-robin victim
  logic [ENTRIES-1:0]      entry_v;
  logic                    w_cmp_v;
  logic                    r_cmp_v;
  logic                    a_wr;
  logic [79:0]             a_q;
  logic [79:0]             b_q;
  arp_pkg::ipv4_t          w_ipv4;
  arp_pkg::mac_addr_t      w_mac;
  arp_pkg::ipv4_t          req_ipv4;
  logic [TMO_W-1:0]        tmo_cnt;
  logic                    w_hit;
  logic                    r_hit;

  arp_table_ram #(
    .TABLE_ADDR_W (TABLE_ADDR_W)
  ) ram_inst (
    .clk    (clk),
    .a_addr (a_addr),
    .a_wr   (a_wr),
    .a_d    ({w_ipv4, w_mac}),
    .a_q    (a_q),
    .b_addr (b_addr),
    .b_q    (b_q)
  );

  // Compare against the entry read on the previous cycle
  assign w_hit = w_cmp_v && entry_v[w_cmp_idx] && (a_q[79:MAC_W] == w_ipv4);
  assign r_hit = r_cmp_v && entry_v[r_cmp_idx] && (b_q[79:MAC_W] == req_ipv4);
  assign a_wr  = (w_state == w_update_s) || (w_state == w_add_s);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      w_state <= w_idle_s;
      w_ptr   <= '0;
      entry_v <= '0;
      w_cmp_v <= 1'b0;
      a_addr  <= '0;
    end else begin
      case (w_state)
        w_idle_s: begin
          w_cmp_v <= 1'b0;
          a_addr  <= '0;
          if (learn_v) w_state <= w_scan_s;
        end
        w_scan_s: begin
          a_addr    <= a_addr + 1'b1;
          w_cmp_idx <= a_addr;
          w_cmp_v   <= 1'b1;
          if (w_hit) begin
            a_addr  <= w_cmp_idx; // Overwrite in place
            w_state <= w_update_s;
          end else if (w_cmp_v && w_cmp_idx == '1) begin
            a_addr  <= w_ptr;
            w_state <= w_add_s;
          end
        end
        w_update_s: begin
          w_state <= w_idle_s;
        end
        w_add_s: begin
          entry_v[a_addr] <= 1'b1;
          w_ptr           <= w_ptr + 1'b1;
          w_state         <= w_idle_s;
        end
        default: w_state <= w_idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (w_state == w_idle_s && learn_v) begin
      w_ipv4 <= learn_ipv4;
      w_mac  <= learn_mac;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      r_state  <= r_idle_s;
      b_addr   <= '0;
      r_cmp_v  <= 1'b0;
      req_ipv4 <= '0;
      tmo_cnt  <= '0;
      arp_val  <= 1'b0;
      arp_err  <= 1'b0;
    end else begin
      arp_err <= 1'b0;
      case (r_state)
        r_idle_s: begin
          r_cmp_v  <= 1'b0;
          b_addr   <= '0;
          req_ipv4 <= ipv4_req;
          if (ipv4_req != req_ipv4 && ipv4_req != '0) begin
            arp_val <= 1'b0;
            r_state <= r_scan_s;
          end
        end
        r_scan_s: begin
          b_addr    <= b_addr + 1'b1;
          r_cmp_idx <= b_addr;
          r_cmp_v   <= 1'b1;
          if (r_hit) begin
            mac_rsp <= b_q[MAC_W-1:0];
            arp_val <= 1'b1;
            r_state <= r_idle_s;
          end else if (r_cmp_v && r_cmp_idx == '1) begin
            r_state <= r_wait_tx_s; // Miss, go ask
          end
        end
        r_wait_tx_s: begin
          tmo_cnt <= '0;
          if (!tx_busy) r_state <= r_wait_reply_s;
        end
        r_wait_reply_s: begin
          tmo_cnt <= tmo_cnt + 1'b1;
          if (learn_v && learn_ipv4 == req_ipv4) begin
            mac_rsp <= learn_mac;
            arp_val <= 1'b1;
            r_state <= r_idle_s;
          end else if (tmo_cnt == TMO_W'(ARP_TIMEOUT_TICKS - 1)) begin
            arp_err <= 1'b1;
            r_state <= r_idle_s;
          end
        end
        default: r_state <= r_idle_s;
      endcase
    end
  end

  assign send_req     = (r_state == r_wait_tx_s) && !tx_busy;
  assign req_dst_ipv4 = req_ipv4;

  a_val_err_excl : assert property (@(posedge clk) disable iff (fsm_rst)
    !(arp_val && arp_err));

endmodule

`default_nettype wire

// ==== arp_table_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module arp_table_ram #(
  parameter int TABLE_ADDR_W = 2
) (
  input  logic                    clk,
  input  logic [TABLE_ADDR_W-1:0] a_addr,
  input  logic                    a_wr,
  input  logic [79:0]             a_d,
  output logic [79:0]             a_q,
  input  logic [TABLE_ADDR_W-1:0] b_addr,
  output logic [79:0]             b_q
);

  localparam int ENTRY_W = $bits(arp_pkg::ipv4_t) + $bits(arp_pkg::mac_addr_t);

  logic [ENTRY_W-1:0] mem [2**TABLE_ADDR_W];

  always_ff @(posedge clk) begin
    if (a_wr) mem[a_addr] <= a_d;
    a_q <= mem[a_addr]; // Old data on a write
    b_q <= mem[b_addr];
  end

endmodule

`default_nettype wire

// ==== arp_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module arp_top #(
  parameter int TABLE_ADDR_W      = 2,
  parameter int ARP_TIMEOUT_TICKS = 1000000
) (
  input  logic               clk,
  input  logic               fsm_rst,
  input  arp_pkg::mac_addr_t dev_mac,
  input  arp_pkg::ipv4_t     dev_ipv4,
  input  arp_pkg::byte_t     rx_d,
  input  logic               rx_v,
  input  logic [15:0]        rx_ethertype,
  input  logic               rx_err,
  input  arp_pkg::ipv4_t     ipv4_req,
  output arp_pkg::mac_addr_t mac_rsp,
  output logic               arp_val,
  output logic               arp_err,
  output arp_pkg::byte_t     tx_d,
  output logic               tx_v,
  output arp_pkg::mac_addr_t tx_dst_mac,
  output logic               tx_busy
);

  logic               learn_v;
  arp_pkg::ipv4_t     learn_ipv4;
  arp_pkg::mac_addr_t learn_mac;
  logic               reply_req;
  arp_pkg::ipv4_t     reply_dst_ipv4;
  arp_pkg::mac_addr_t reply_dst_mac;
  logic               send_req;
  arp_pkg::ipv4_t     req_dst_ipv4;
  logic               tx_done;
  logic               send_tx;
  arp_pkg::arp_oper_t tx_oper;
  arp_pkg::mac_addr_t tx_mac;
  arp_pkg::ipv4_t     tx_ipv4;
  logic               pend;
  arp_pkg::ipv4_t     pend_ipv4;
  arp_pkg::mac_addr_t pend_mac;
  logic               tx_free;
  logic               go_pend;
  logic               go_req;
  logic               go_rep;
  logic               hold_rep;

  arp_rx rx_inst (
    .clk            (clk),
    .fsm_rst        (fsm_rst),
    .dev_ipv4       (dev_ipv4),
    .rx_d           (rx_d),
    .rx_v           (rx_v),
    .rx_ethertype   (rx_ethertype),
    .rx_err         (rx_err),
    .learn_v        (learn_v),
    .learn_ipv4     (learn_ipv4),
    .learn_mac      (learn_mac),
    .reply_req      (reply_req),
    .reply_dst_ipv4 (reply_dst_ipv4),
    .reply_dst_mac  (reply_dst_mac)
  );

  arp_tx tx_inst (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .dev_mac    (dev_mac),
    .dev_ipv4   (dev_ipv4),
    .send       (send_tx),
    .oper       (tx_oper),
    .dst_mac    (tx_mac),
    .dst_ipv4   (tx_ipv4),
    .tx_d       (tx_d),
    .tx_v       (tx_v),
    .tx_dst_mac (tx_dst_mac),
    .busy       (tx_busy),
    .done       (tx_done)
  );

  // Table sees tx as busy while a send is queued or a reply waits
  arp_table #(
    .TABLE_ADDR_W      (TABLE_ADDR_W),
    .ARP_TIMEOUT_TICKS (ARP_TIMEOUT_TICKS)
  ) table_inst (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .learn_v      (learn_v),
    .learn_ipv4   (learn_ipv4),
    .learn_mac    (learn_mac),
    .ipv4_req     (ipv4_req),
    .mac_rsp      (mac_rsp),
    .arp_val      (arp_val),
    .arp_err      (arp_err),
    .tx_busy      (!tx_free || pend),
    .send_req     (send_req),
    .req_dst_ipv4 (req_dst_ipv4)
  );

  assign tx_free  = (!tx_busy || tx_done) && !send_tx; // Last byte frees tx
  assign go_pend  = pend && tx_free;
  assign go_req   = !go_pend && send_req;
  assign go_rep   = !go_pend && !send_req && reply_req && !pend && tx_free;
  assign hold_rep = reply_req && !pend && !go_rep; // Second reply while pending is lost

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      send_tx <= 1'b0;
      pend    <= 1'b0;
    end else begin
      send_tx <= go_pend || go_req || go_rep;
      pend    <= (pend && !go_pend) || hold_rep;
    end
  end

  always_ff @(posedge clk) begin
    if (hold_rep) begin
      pend_ipv4 <= reply_dst_ipv4;
      pend_mac  <= reply_dst_mac;
    end
    if (go_pend) begin
      tx_oper <= arp_pkg::OPER_REPLY;
      tx_mac  <= pend_mac;
      tx_ipv4 <= pend_ipv4;
    end else if (go_req) begin
      tx_oper <= arp_pkg::OPER_REQUEST;
      tx_mac  <= arp_pkg::BROADCAST_MAC;
      tx_ipv4 <= req_dst_ipv4;
    end else if (go_rep) begin
      tx_oper <= arp_pkg::OPER_REPLY;
      tx_mac  <= reply_dst_mac;
      tx_ipv4 <= reply_dst_ipv4;
    end
  end

endmodule

`default_nettype wire

// ==== arp_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module arp_tx (
  input  logic               clk,
  input  logic               fsm_rst,
  input  arp_pkg::mac_addr_t dev_mac,
  input  arp_pkg::ipv4_t     dev_ipv4,
  input  logic               send,
  input  arp_pkg::arp_oper_t oper,
  input  arp_pkg::mac_addr_t dst_mac,
  input  arp_pkg::ipv4_t     dst_ipv4,
  output arp_pkg::byte_t     tx_d,
  output logic               tx_v,
  output arp_pkg::mac_addr_t tx_dst_mac,
  output logic               busy,
  output logic               done
);

  localparam int          HDR_W      = arp_pkg::ARP_HDR_LEN * 8;
  localparam logic [15:0] HTYPE_ETH  = 16'd1;
  localparam logic [15:0] PTYPE_IPV4 = 16'h0800;

  typedef enum logic {tx_idle_s, tx_send_s} tx_state_t;

  tx_state_t        state;
  logic [5:0]       byte_cnt;
  logic [HDR_W-1:0] shreg;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= tx_idle_s;
      byte_cnt <= '0;
    end else begin
      case (state)
        tx_idle_s: begin
          byte_cnt <= '0;
          if (send) state <= tx_send_s;
        end
        tx_send_s: begin
          byte_cnt <= byte_cnt + 6'd1;
          if (done) state <= tx_idle_s;
        end
        default: state <= tx_idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == tx_idle_s && send) begin
      // hlen 6, plen 4
      shreg <= {HTYPE_ETH, PTYPE_IPV4, 8'd6, 8'd4, oper,
                dev_mac, dev_ipv4, dst_mac, dst_ipv4};
      tx_dst_mac <= dst_mac;
    end else if (state == tx_send_s) begin
      shreg <= {shreg[HDR_W-9:0], 8'h00}; // Zeros shift in for the padding
    end
  end

  assign tx_d = shreg[HDR_W-1 -: 8];
  assign busy = (state == tx_send_s);
  assign tx_v = busy;
  assign done = busy && (byte_cnt == 6'(arp_pkg::ARP_FRAME_LEN - 1));

  a_no_send_busy : assert property (@(posedge clk) disable iff (fsm_rst)
    send |-> !busy);

endmodule

`default_nettype wire

// ==== tb_arp.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_arp;

  localparam int TABLE_ADDR_W = 2;
  localparam int TIMEOUT      = 300;
  localparam int CLK_PERIOD   = 40;
  localparam int NUM_ROWS     = 17;
  localparam int FRAME_LEN    = arp_pkg::ARP_FRAME_LEN;
  localparam int SCAN_CYCLES  = 2 ** TABLE_ADDR_W + 3;
  localparam int SETTLE       = SCAN_CYCLES + 4;
  localparam int ROW_CYCLES   = 2 * FRAME_LEN + TIMEOUT + SCAN_CYCLES + 40;

  localparam int ACT_RX           = 0;
  localparam int ACT_LOOKUP       = 1;
  localparam int ACT_RX_IN_LOOKUP = 2;
  localparam int RES_NONE = 0;
  localparam int RES_VAL  = 1;
  localparam int RES_ERR  = 2;

  localparam logic [15:0]    ETH_ARP = arp_pkg::ETHERTYPE_ARP;
  localparam logic [15:0]    ETH_IP  = 16'h0800;
  localparam logic [15:0]    REQ     = arp_pkg::OPER_REQUEST;
  localparam logic [15:0]    REP     = arp_pkg::OPER_REPLY;
  localparam arp_pkg::ipv4_t DEV_IP  = 32'h0a000001;

  typedef struct packed {
    logic [1:0]  act;
    logic [15:0] etype;
    logic [15:0] oper;
    logic [31:0] sip;
    logic [2:0]  smac_i;
    logic [31:0] tip;
    logic [5:0]  err_pos;  // Byte that carries rx_err, 0 for none
    logic [31:0] look_ip;
    logic [5:0]  rx_delay;
    logic        tx_req;
    logic        tx_rep;
    logic [1:0]  res;
    logic [2:0]  mac_i;
  } row_t;

  logic               clk;
  logic               fsm_rst;
  arp_pkg::mac_addr_t dev_mac;
  arp_pkg::ipv4_t     dev_ipv4;
  arp_pkg::byte_t     rx_d;
  logic               rx_v;
  logic [15:0]        rx_ethertype;
  logic               rx_err;
  arp_pkg::ipv4_t     ipv4_req;
  arp_pkg::mac_addr_t mac_rsp;
  logic               arp_val;
  logic               arp_err;
  arp_pkg::byte_t     tx_d;
  logic               tx_v;
  arp_pkg::mac_addr_t tx_dst_mac;
  logic               tx_busy;

  row_t               rows [NUM_ROWS];
  arp_pkg::mac_addr_t peer_mac [8];
  arp_pkg::byte_t     frame_buf [FRAME_LEN];
  arp_pkg::byte_t     rx_buf [FRAME_LEN];
  arp_pkg::byte_t     exp_bytes [$];
  arp_pkg::mac_addr_t exp_dst [$];
  int                 tx_cnt;
  logic [31:0]        lcg_state;

  arp_top #(
    .TABLE_ADDR_W      (TABLE_ADDR_W),
    .ARP_TIMEOUT_TICKS (TIMEOUT)
  ) uut (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .dev_mac      (dev_mac),
    .dev_ipv4     (dev_ipv4),
    .rx_d         (rx_d),
    .rx_v         (rx_v),
    .rx_ethertype (rx_ethertype),
    .rx_err       (rx_err),
    .ipv4_req     (ipv4_req),
    .mac_rsp      (mac_rsp),
    .arp_val      (arp_val),
    .arp_err      (arp_err),
    .tx_d         (tx_d),
    .tx_v         (tx_v),
    .tx_dst_mac   (tx_dst_mac),
    .tx_busy      (tx_busy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((NUM_ROWS * ROW_CYCLES + 20) * CLK_PERIOD);
    $display("Watchdog expired, the run timed out before all rows were done");
    $display("ERRORS FOUND");
    $fatal(1, "timeout");
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "check failed");
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic arp_pkg::mac_addr_t rand_mac();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:24] & 8'hfe, hi[23:16], lo}; // Unicast only
  endfunction

  function automatic arp_pkg::ipv4_t peer_ip(input int n);
    return {24'h0a0000, n[7:0]};
  endfunction

  function automatic row_t make_row(input int act, input logic [15:0] etype,
                                    input logic [15:0] oper, input arp_pkg::ipv4_t sip,
                                    input int smac_i, input arp_pkg::ipv4_t tip,
                                    input int err_pos, input arp_pkg::ipv4_t look_ip,
                                    input int rx_delay, input logic tx_req, input logic tx_rep,
                                    input int res, input int mac_i);
    row_t r;
    r.act      = act[1:0];
    r.etype    = etype;
    r.oper     = oper;
    r.sip      = sip;
    r.smac_i   = smac_i[2:0];
    r.tip      = tip;
    r.err_pos  = err_pos[5:0];
    r.look_ip  = look_ip;
    r.rx_delay = rx_delay[5:0];
    r.tx_req   = tx_req;
    r.tx_rep   = tx_rep;
    r.res      = res[1:0];
    r.mac_i    = mac_i[2:0];
    return r;
  endfunction

  // Payload: htype, ptype, hlen, plen, oper, sender, target, zero pad
  task automatic build_frame(input arp_pkg::arp_oper_t oper, input arp_pkg::mac_addr_t smac,
                             input arp_pkg::ipv4_t sip, input arp_pkg::mac_addr_t tmac,
                             input arp_pkg::ipv4_t tip);
    logic [223:0] fields;
    fields = {16'h0001, 16'h0800, 8'd6, 8'd4, oper, smac, sip, tmac, tip};
    for (int i = 0; i < FRAME_LEN; i++) begin
      if (i < 28) frame_buf[i] = fields[223 - 8 * i -: 8];
      else frame_buf[i] = 8'h00;
    end
  endtask

  task automatic expect_frame(input arp_pkg::mac_addr_t dst);
    for (int i = 0; i < FRAME_LEN; i++) exp_bytes.push_back(frame_buf[i]);
    exp_dst.push_back(dst);
  endtask

  task automatic receive_frame(input logic [15:0] etype, input int err_pos);
    for (int i = 0; i < FRAME_LEN; i++) begin
      @(negedge clk);
      rx_v         = 1'b1;
      rx_d         = rx_buf[i];
      rx_ethertype = etype;
      rx_err       = (i + 1 == err_pos);
    end
    @(negedge clk);
    rx_v   = 1'b0;
    rx_err = 1'b0;
    rx_d   = '0;
  endtask

  task automatic lookup(input arp_pkg::ipv4_t ip, input int res, input int mac_i,
                        input logic via_miss);
    int cycles;
    @(negedge clk);
    ipv4_req = '0; // Lets the same IP start a new lookup
    @(negedge clk);
    ipv4_req = ip;
    @(negedge clk);
    cycles = 1;
    check_value(arp_val, 1'b0, "arp_val still high after lookup start");
    while (!arp_val && !arp_err) begin
      @(negedge clk);
      cycles++;
    end
    if (res == RES_VAL) begin
      check_value({arp_val, arp_err}, 2'b10, "lookup outcome, expected arp_val");
      check_value(mac_rsp, peer_mac[mac_i], "mac_rsp");
      if (!via_miss) check_value(cycles <= SCAN_CYCLES, 1'b1, "hit latency too long");
    end else begin
      check_value({arp_val, arp_err}, 2'b01, "lookup outcome, expected arp_err");
      @(negedge clk);
      check_value(arp_err, 1'b0, "arp_err longer than one cycle");
    end
  endtask

  task automatic run_row(input int r);
    row_t s;
    logic [47:0] tmac;
    s = rows[r];
    tmac = (s.oper == REP) ? dev_mac : '0;
    build_frame(s.oper, peer_mac[s.smac_i], s.sip, tmac, s.tip);
    rx_buf = frame_buf;
    if (s.tx_req) begin
      build_frame(REQ, dev_mac, dev_ipv4, arp_pkg::BROADCAST_MAC, s.look_ip);
      expect_frame(arp_pkg::BROADCAST_MAC);
    end
    if (s.tx_rep) begin
      build_frame(REP, dev_mac, dev_ipv4, peer_mac[s.smac_i], s.sip);
      expect_frame(peer_mac[s.smac_i]);
    end
    case (s.act)
      ACT_RX: receive_frame(s.etype, s.err_pos);
      ACT_LOOKUP: lookup(s.look_ip, s.res, s.mac_i, s.tx_req);
      default: begin
        fork
          begin
            repeat (s.rx_delay) @(negedge clk);
            receive_frame(s.etype, s.err_pos);
          end
          lookup(s.look_ip, s.res, s.mac_i, s.tx_req);
        join
      end
    endcase
    while (exp_bytes.size() != 0 || tx_cnt != 0) @(negedge clk);
    repeat (SETTLE) @(negedge clk); // Any extra frame shows up here
  endtask

  // Checks each transmitted byte against the queued frames
  always @(negedge clk) begin
    if (!fsm_rst && tx_v) begin
      check_value(tx_busy, 1'b1, "tx_busy low during a frame");
      if (tx_cnt == 0) begin
        check_value(exp_dst.size() != 0, 1'b1, "frame transmitted when none was expected");
        check_value(tx_dst_mac, exp_dst.pop_front(), "tx_dst_mac");
      end
      check_value(tx_d, exp_bytes.pop_front(), $sformatf("tx byte %0d", tx_cnt));
      tx_cnt++;
    end else begin
      if (!fsm_rst) check_value(tx_busy, 1'b0, "tx_busy high outside a frame");
      if (tx_cnt != 0) begin
        check_value(tx_cnt, FRAME_LEN, "tx frame length");
        tx_cnt = 0;
      end
    end
  end

  initial begin
    fsm_rst      = 1'b1;
    dev_mac      = 48'h020000000001;
    dev_ipv4     = DEV_IP;
    rx_d         = '0;
    rx_v         = 1'b0;
    rx_ethertype = ETH_ARP;
    rx_err       = 1'b0;
    ipv4_req     = '0;
    tx_cnt       = 0;
    lcg_state    = 32'd16;
    for (int i = 0; i < 8; i++) peer_mac[i] = rand_mac();

    // act, ethertype, oper, sender ip, sender mac, target ip, err byte,
    // lookup ip, rx delay, request out, reply out, result, mac_rsp
    rows[0]  = make_row(ACT_RX, ETH_ARP, REQ, peer_ip(10), 0, DEV_IP, 0,
                        '0, 0, 1'b0, 1'b1, RES_NONE, 0);
    rows[1]  = make_row(ACT_LOOKUP, ETH_ARP, '0, '0, 0, '0, 0,
                        peer_ip(10), 0, 1'b0, 1'b0, RES_VAL, 0);
    rows[2]  = make_row(ACT_RX_IN_LOOKUP, ETH_ARP, REP, peer_ip(20), 1, DEV_IP, 0,
                        peer_ip(20), 10, 1'b1, 1'b0, RES_VAL, 1);
    rows[3]  = make_row(ACT_LOOKUP, ETH_ARP, '0, '0, 0, '0, 0,
                        peer_ip(30), 0, 1'b1, 1'b0, RES_ERR, 0);
    rows[4]  = make_row(ACT_RX, ETH_ARP, REQ, peer_ip(40), 2, peer_ip(99), 0,
                        '0, 0, 1'b0, 1'b0, RES_NONE, 0);
    rows[5]  = make_row(ACT_LOOKUP, ETH_ARP, '0, '0, 0, '0, 0,
                        peer_ip(40), 0, 1'b0, 1'b0, RES_VAL, 2);
    rows[6]  = make_row(ACT_RX, ETH_IP, REQ, peer_ip(50), 3, DEV_IP, 0,
                        '0, 0, 1'b0, 1'b0, RES_NONE, 0);
    rows[7]  = make_row(ACT_LOOKUP, ETH_ARP, '0, '0, 0, '0, 0,
                        peer_ip(50), 0, 1'b1, 1'b0, RES_ERR, 0);
    rows[8]  = make_row(ACT_RX, ETH_ARP, REQ, peer_ip(60), 4, DEV_IP, 20,
                        '0, 0, 1'b0, 1'b0, RES_NONE, 0);
    rows[9]  = make_row(ACT_LOOKUP, ETH_ARP, '0, '0, 0, '0, 0,
                        peer_ip(60), 0, 1'b1, 1'b0, RES_ERR, 0);
    rows[10] = make_row(ACT_RX, ETH_ARP, REP, peer_ip(10), 5, DEV_IP, 0,
                        '0, 0, 1'b0, 1'b0, RES_NONE, 0);
    rows[11] = make_row(ACT_LOOKUP, ETH_ARP, '0, '0, 0, '0, 0,
                        peer_ip(10), 0, 1'b0, 1'b0, RES_VAL, 5);
    rows[12] = make_row(ACT_RX, ETH_ARP, REP, peer_ip(70), 6, DEV_IP, 0,
                        '0, 0, 1'b0, 1'b0, RES_NONE, 0);
    rows[13] = make_row(ACT_RX, ETH_ARP, REP, peer_ip(80), 7, DEV_IP, 0,
                        '0, 0, 1'b0, 1'b0, RES_NONE, 0);
    rows[14] = make_row(ACT_LOOKUP, ETH_ARP, '0, '0, 0, '0, 0,
                        peer_ip(10), 0, 1'b1, 1'b0, RES_ERR, 0);
    rows[15] = make_row(ACT_LOOKUP, ETH_ARP, '0, '0, 0, '0, 0,
                        peer_ip(80), 0, 1'b0, 1'b0, RES_VAL, 7);
    // Peer request lands while the broadcast is still going out
    rows[16] = make_row(ACT_RX_IN_LOOKUP, ETH_ARP, REQ, peer_ip(100), 3, DEV_IP, 0,
                        peer_ip(90), 0, 1'b1, 1'b1, RES_ERR, 0);

    repeat (4) @(negedge clk);
    fsm_rst = 1'b0;
    @(negedge clk);
    check_value({tx_v, tx_busy, arp_val, arp_err}, 4'b0000, "outputs after reset");

    for (int r = 0; r < NUM_ROWS; r++) run_row(r);

    if (exp_bytes.size() == 0 && exp_dst.size() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("Frames still expected at the end of the run");
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
